// File: flist.f
hdl/ooo_pkg.sv
hdl/rs_entry.sv
hdl/rs_bank.sv
hdl/fu_select.sv
hdl/int_alu.sv
hdl/issue_execute_top.sv
tests/tb_issue_execute.sv

// File: Bender.yml
package:
  name: issue_execute

sources:
  - files:
      - hdl/ooo_pkg.sv
      - hdl/rs_entry.sv
      - hdl/rs_bank.sv
      - hdl/fu_select.sv
      - hdl/int_alu.sv
      - hdl/issue_execute_top.sv
  - target: test
    files:
      - tests/tb_issue_execute.sv

// File: tests/tb_issue_execute.sv
//////////////////////////////
// Issue and execute testbench
// Directed tests for stations, select and CDB
//////////////////////////////

`timescale 1ns/1ps

module tb_issue_execute import ooo_pkg::*; ;
    localparam int NUM_RS = 4;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int BC_TIMEOUT = 10;
    // Rough per-test lengths in cycles are doubled below for margin
    localparam int TEST_CYCLES = 20 + 20 + 14 + 12 + 10 + 14;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * TEST_CYCLES;

    logic              clk;
    logic              reset;
    logic              mispredicted;
    logic              stall;
    rs_sel_t           rs_dest;
    alu_op_t           d_alu_op;
    br_type_t          d_branch_type;
    rob_tag_t          d_rob_entry;
    rob_tag_t          d_qj;
    rob_tag_t          d_qk;
    word_t             d_vj;
    word_t             d_vk;
    logic [NUM_RS-1:0] busy_bus;
    logic              cdb_valid;
    rob_tag_t          cdb_rob_entry;
    word_t             cdb_result;
    logic              cdb_branch_taken;

    integer seed;
    int     err_cnt = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     neg_cnt = 0;
    int     drive_stamp;

    // Broadcast log filled at falling edges
    rob_tag_t          log_tag   [$];
    word_t             log_res   [$];
    logic              log_taken [$];
    logic [NUM_RS-1:0] log_busy  [$];
    int                log_stamp [$];

    issue_execute_top #(.NUM_RS(NUM_RS)) uut (
        .clk              (clk),
        .reset            (reset),
        .mispredicted     (mispredicted),
        .stall            (stall),
        .rs_dest          (rs_dest),
        .d_alu_op         (d_alu_op),
        .d_branch_type    (d_branch_type),
        .d_rob_entry      (d_rob_entry),
        .d_qj             (d_qj),
        .d_qk             (d_qk),
        .d_vj             (d_vj),
        .d_vk             (d_vk),
        .busy_bus         (busy_bus),
        .cdb_valid        (cdb_valid),
        .cdb_rob_entry    (cdb_rob_entry),
        .cdb_result       (cdb_result),
        .cdb_branch_taken (cdb_branch_taken)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        neg_cnt++;
        if (!reset && cdb_valid === 1'b1) begin
            log_tag.push_back(cdb_rob_entry);
            log_res.push_back(cdb_result);
            log_taken.push_back(cdb_branch_taken);
            log_busy.push_back(busy_bus);
            log_stamp.push_back(neg_cnt);
        end
    end

    // Reference ALU and branch rules
    function automatic word_t model_result(input alu_op_t op, input br_type_t br,
                                           input word_t a, input word_t b);
        word_t r;
        if (br != BR_NONE) begin
            r = a + b;
        end else begin
            case (op)
                ALU_ADD: r = a + b;
                ALU_SUB: r = a - b;
                ALU_AND: r = a & b;
                ALU_OR:  r = a | b;
                ALU_XOR: r = a ^ b;
                ALU_SLL: r = a << b[4:0];
                ALU_SRL: r = a >> b[4:0];
                default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            endcase
        end
        return r;
    endfunction

    function automatic logic model_taken(input br_type_t br, input word_t a, input word_t b);
        case (br)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic dispatch(input rs_sel_t sel, input alu_op_t op, input br_type_t br,
                            input rob_tag_t rob, input rob_tag_t qj, input rob_tag_t qk,
                            input word_t vj, input word_t vk);
        @(posedge clk);
        rs_dest       <= sel;
        d_alu_op      <= op;
        d_branch_type <= br;
        d_rob_entry   <= rob;
        d_qj          <= qj;
        d_qk          <= qk;
        d_vj          <= vj;
        d_vk          <= vk;
        drive_stamp = neg_cnt;
    endtask

    task automatic go_idle();
        @(posedge clk);
        rs_dest <= rs_sel_t'(NUM_RS);
    endtask

    task automatic clear_log();
        log_tag.delete();
        log_res.delete();
        log_taken.delete();
        log_busy.delete();
        log_stamp.delete();
    endtask

    // Pops the next broadcast and checks its payload, timing and freed station
    task automatic expect_broadcast(input int sel, input rob_tag_t tag, input word_t res,
                                    input logic tk, input int stamp);
        int waited;
        logic [NUM_RS-1:0] busy_seen;
        waited = 0;
        while (log_tag.size() == 0 && waited < BC_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (log_tag.size() != 0) else begin
            $display("Timeout at %0d ns: no CDB broadcast for ROB entry %0d", $time, tag);
            err_cnt++;
        end
        if (log_tag.size() != 0) begin
            busy_seen = log_busy.pop_front();
            check_value("cdb_rob_entry", tag, log_tag.pop_front());
            check_value("cdb_result", res, log_res.pop_front());
            check_value("cdb_branch_taken", tk, log_taken.pop_front());
            check_value("cdb_valid cycle", stamp, log_stamp.pop_front());
            check_value($sformatf("busy_bus[%0d]", sel), 1'b0, busy_seen[sel]);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(posedge clk);
        assert (log_tag.size() == 0) else begin
            $display("Unexpected CDB broadcast for ROB entry %0d before %0d ns",
                     log_tag[0], $time);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d error(s)", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_independent();
        int    errs;
        int    i;
        word_t va [8];
        word_t vb [8];
        int    stamps [8];
        errs = err_cnt;
        clear_log();
        for (i = 0; i < 8; i++) begin
            va[i] = $random(seed);
            vb[i] = $random(seed);
            dispatch(rs_sel_t'(i % NUM_RS), alu_op_t'(i), BR_NONE, rob_tag_t'(i + 1),
                     '0, '0, va[i], vb[i]);
            stamps[i] = drive_stamp;
        end
        go_idle();
        for (i = 0; i < 8; i++) begin
            expect_broadcast(i % NUM_RS, rob_tag_t'(i + 1),
                             model_result(alu_op_t'(i), BR_NONE, va[i], vb[i]), 1'b0,
                             stamps[i] + 3);
        end
        finish_test("independent ops", errs);
    endtask

    task automatic test_dependency();
        int    errs;
        int    s0;
        int    s1;
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t p0;
        word_t p1;
        errs = err_cnt;
        clear_log();
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        d = $random(seed);
        p0 = model_result(ALU_ADD, BR_NONE, a, b);
        dispatch(0, ALU_ADD, BR_NONE, 4'd5, 4'd0, 4'd0, a, b);
        s0 = drive_stamp;
        // Station 1 waits on ROB 5 for its first operand
        dispatch(1, ALU_SUB, BR_NONE, 4'd6, 4'd5, 4'd0, 32'd0, c);
        go_idle();
        expect_broadcast(0, 4'd5, p0, 1'b0, s0 + 3);
        expect_broadcast(1, 4'd6, model_result(ALU_SUB, BR_NONE, p0, c), 1'b0, s0 + 5);
        p1 = model_result(ALU_OR, BR_NONE, c, d);
        dispatch(2, ALU_OR, BR_NONE, 4'd7, 4'd0, 4'd0, c, d);
        s1 = drive_stamp;
        go_idle();
        // Written on the edge that sees the producer's broadcast
        dispatch(3, ALU_XOR, BR_NONE, 4'd8, 4'd0, 4'd7, d, 32'd0);
        go_idle();
        expect_broadcast(2, 4'd7, p1, 1'b0, s1 + 3);
        expect_broadcast(3, 4'd8, model_result(ALU_XOR, BR_NONE, d, p1), 1'b0, s1 + 5);
        finish_test("dependency wakeup", errs);
    endtask

    task automatic test_select_order();
        int    errs;
        int    s0;
        word_t p;
        errs = err_cnt;
        clear_log();
        p = $random(seed);
        // Out of index order and all waiting on ROB 9
        dispatch(3, ALU_ADD, BR_NONE, 4'd13, 4'd9, 4'd0, 32'd0, 32'd3);
        dispatch(1, ALU_ADD, BR_NONE, 4'd11, 4'd9, 4'd0, 32'd0, 32'd1);
        dispatch(2, ALU_ADD, BR_NONE, 4'd12, 4'd9, 4'd0, 32'd0, 32'd2);
        dispatch(0, ALU_OR, BR_NONE, 4'd9, 4'd0, 4'd0, p, 32'd0);
        s0 = drive_stamp;
        go_idle();
        expect_broadcast(0, 4'd9, p, 1'b0, s0 + 3);
        expect_broadcast(1, 4'd11, model_result(ALU_ADD, BR_NONE, p, 32'd1), 1'b0, s0 + 5);
        expect_broadcast(2, 4'd12, model_result(ALU_ADD, BR_NONE, p, 32'd2), 1'b0, s0 + 6);
        expect_broadcast(3, 4'd13, model_result(ALU_ADD, BR_NONE, p, 32'd3), 1'b0, s0 + 7);
        finish_test("select order", errs);
    endtask

    task automatic test_stall_no_target();
        int errs;
        errs = err_cnt;
        clear_log();
        // Station 2 parks on a tag nobody produces
        dispatch(2, ALU_ADD, BR_NONE, 4'd1, 4'd14, 4'd0, 32'd0, 32'd1);
        dispatch(0, ALU_ADD, BR_NONE, 4'd2, 4'd0, 4'd0, 32'd4, 32'd5);
        stall <= 1'b1;
        dispatch(4, ALU_ADD, BR_NONE, 4'd3, 4'd0, 4'd0, 32'd6, 32'd7);
        stall <= 1'b0;
        dispatch(7, ALU_ADD, BR_NONE, 4'd4, 4'd0, 4'd0, 32'd8, 32'd9);
        go_idle();
        expect_quiet(4);
        @(negedge clk);
        check_value("busy_bus", 4'b0100, busy_bus);
        finish_test("stall and no target", errs);
    endtask

    task automatic test_flush();
        int errs;
        errs = err_cnt;
        clear_log();
        dispatch(1, ALU_SUB, BR_NONE, 4'd5, 4'd0, 4'd15, 32'd9, 32'd0);
        dispatch(0, ALU_ADD, BR_NONE, 4'd6, 4'd0, 4'd0, 32'd1, 32'd2);
        go_idle();
        // Lands on the edge where station 0 issues
        mispredicted <= 1'b1;
        @(negedge clk);
        check_value("busy_bus", 4'b0111, busy_bus);
        @(posedge clk);
        mispredicted <= 1'b0;
        @(negedge clk);
        check_value("busy_bus", 4'b0000, busy_bus);
        check_value("cdb_valid", 1'b0, cdb_valid);
        expect_quiet(5);
        finish_test("mispredict flush", errs);
    endtask

    task automatic test_branches();
        int       errs;
        int       i;
        int       stamps [7];
        br_type_t br_list [7] = '{BR_EQ, BR_EQ, BR_NE, BR_NE, BR_LT, BR_LT, BR_LT};
        word_t    a_list [7] = '{32'd5, 32'd5, 32'd5, 32'd7, 32'hFFFF_FFFD, 32'd2,
                                 32'h8000_0000};
        word_t    b_list [7] = '{32'd5, 32'd6, 32'd6, 32'd7, 32'd2, 32'hFFFF_FFFD,
                                 32'h7FFF_FFFF};
        errs = err_cnt;
        clear_log();
        for (i = 0; i < 7; i++) begin
            dispatch(rs_sel_t'(i % NUM_RS), ALU_ADD, br_list[i], rob_tag_t'(i + 1),
                     '0, '0, a_list[i], b_list[i]);
            stamps[i] = drive_stamp;
        end
        go_idle();
        for (i = 0; i < 7; i++) begin
            expect_broadcast(i % NUM_RS, rob_tag_t'(i + 1),
                             model_result(ALU_ADD, br_list[i], a_list[i], b_list[i]),
                             model_taken(br_list[i], a_list[i], b_list[i]), stamps[i] + 3);
        end
        finish_test("branches", errs);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed = 67;
        reset = 1'b1;
        mispredicted = 1'b0;
        stall = 1'b0;
        rs_dest = rs_sel_t'(NUM_RS);
        d_alu_op = ALU_ADD;
        d_branch_type = BR_NONE;
        d_rob_entry = '0;
        d_qj = '0;
        d_qk = '0;
        d_vj = '0;
        d_vk = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        test_independent();
        test_dependency();
        test_select_order();
        test_stall_no_target();
        test_flush();
        test_branches();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/issue_execute_top.sv
//////////////////////////////
// Issue and execute slice
// Stations, select and ALU on one CDB
//////////////////////////////

`timescale 1ns/1ps

module issue_execute_top import ooo_pkg::*; #(
    parameter int NUM_RS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mispredicted,
    input  logic              stall,
    input  rs_sel_t           rs_dest,
    input  alu_op_t           d_alu_op,
    input  br_type_t          d_branch_type,
    input  rob_tag_t          d_rob_entry,
    input  rob_tag_t          d_qj,
    input  rob_tag_t          d_qk,
    input  word_t             d_vj,
    input  word_t             d_vk,
    output logic [NUM_RS-1:0] busy_bus,
    output logic              cdb_valid,
    output rob_tag_t          cdb_rob_entry,
    output word_t             cdb_result,
    output logic              cdb_branch_taken
);
    logic [NUM_RS-1:0] ready_bus;
    logic [NUM_RS-1:0] consume;

    alu_op_t  rs_alu_op      [NUM_RS];
    br_type_t rs_branch_type [NUM_RS];
    rob_tag_t rs_rob_entry   [NUM_RS];
    word_t    rs_vj          [NUM_RS];
    word_t    rs_vk          [NUM_RS];

    logic     issue_valid;
    alu_op_t  issue_alu_op;
    br_type_t issue_branch_type;
    rob_tag_t issue_rob_entry;
    word_t    issue_vj;
    word_t    issue_vk;

    rs_bank #(.NUM_RS(NUM_RS)) u_bank (
        .clk           (clk),
        .reset         (reset),
        .mispredicted  (mispredicted),
        .stall         (stall),
        .rs_dest       (rs_dest),
        .d_alu_op      (d_alu_op),
        .d_branch_type (d_branch_type),
        .d_rob_entry   (d_rob_entry),
        .d_qj          (d_qj),
        .d_qk          (d_qk),
        .d_vj          (d_vj),
        .d_vk          (d_vk),
        .cdb_valid     (cdb_valid),
        .cdb_rob_entry (cdb_rob_entry),
        .cdb_result    (cdb_result),
        .consume       (consume),
        .busy_bus      (busy_bus),
        .ready_bus     (ready_bus),
        .alu_op        (rs_alu_op),
        .branch_type   (rs_branch_type),
        .rob_entry     (rs_rob_entry),
        .vj            (rs_vj),
        .vk            (rs_vk)
    );

    // Consume goes back to the bank in the issue cycle
    fu_select #(.NUM_RS(NUM_RS)) u_select (
        .ready_bus         (ready_bus),
        .alu_op            (rs_alu_op),
        .branch_type       (rs_branch_type),
        .rob_entry         (rs_rob_entry),
        .vj                (rs_vj),
        .vk                (rs_vk),
        .issue_valid       (issue_valid),
        .issue_alu_op      (issue_alu_op),
        .issue_branch_type (issue_branch_type),
        .issue_rob_entry   (issue_rob_entry),
        .issue_vj          (issue_vj),
        .issue_vk          (issue_vk),
        .consume           (consume)
    );

    int_alu u_alu (
        .clk               (clk),
        .reset             (reset),
        .mispredicted      (mispredicted),
        .issue_valid       (issue_valid),
        .issue_alu_op      (issue_alu_op),
        .issue_branch_type (issue_branch_type),
        .issue_rob_entry   (issue_rob_entry),
        .issue_vj          (issue_vj),
        .issue_vk          (issue_vk),
        .cdb_valid         (cdb_valid),
        .cdb_rob_entry     (cdb_rob_entry),
        .cdb_result        (cdb_result),
        .cdb_branch_taken  (cdb_branch_taken)
    );

endmodule

// File: hdl/int_alu.sv
//////////////////////////////
// Integer ALU
// Single-cycle ops and branch compare,
// registered onto the CDB
//////////////////////////////

`timescale 1ns/1ps

module int_alu import ooo_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mispredicted,
    input  logic     issue_valid,
    input  alu_op_t  issue_alu_op,
    input  br_type_t issue_branch_type,
    input  rob_tag_t issue_rob_entry,
    input  word_t    issue_vj,
    input  word_t    issue_vk,
    output logic     cdb_valid,
    output rob_tag_t cdb_rob_entry,
    output word_t    cdb_result,
    output logic     cdb_branch_taken
);
    logic [4:0] shamt;
    logic       lt_signed;
    word_t      result;
    logic       taken;

    assign shamt     = issue_vk[4:0];
    assign lt_signed = $signed(issue_vj) < $signed(issue_vk);

    always_comb begin
        result = issue_vj + issue_vk;
        taken  = 1'b0;
        if (issue_branch_type == BR_NONE) begin
            case (issue_alu_op)
                ALU_ADD: result = issue_vj + issue_vk;
                ALU_SUB: result = issue_vj - issue_vk;
                ALU_AND: result = issue_vj & issue_vk;
                ALU_OR:  result = issue_vj | issue_vk;
                ALU_XOR: result = issue_vj ^ issue_vk;
                ALU_SLL: result = issue_vj << shamt;
                ALU_SRL: result = issue_vj >> shamt;
                default: result = {{($bits(word_t) - 1){1'b0}}, lt_signed};
            endcase
        end else begin
            // Branch result word is the sum, only the outcome matters
            case (issue_branch_type)
                BR_EQ:   taken = (issue_vj == issue_vk);
                BR_NE:   taken = (issue_vj != issue_vk);
                default: taken = lt_signed;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || mispredicted) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    // CDB payload
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_rob_entry    <= issue_rob_entry;
            cdb_result       <= result;
            cdb_branch_taken <= taken;
        end
    end

endmodule

// File: hdl/fu_select.sv
//////////////////////////////
// Issue select
// Lowest ready station goes to the ALU
//////////////////////////////

`timescale 1ns/1ps

module fu_select import ooo_pkg::*; #(
    parameter int NUM_RS = 4
) (
    input  logic [NUM_RS-1:0] ready_bus,
    input  alu_op_t           alu_op      [NUM_RS],
    input  br_type_t          branch_type [NUM_RS],
    input  rob_tag_t          rob_entry   [NUM_RS],
    input  word_t             vj          [NUM_RS],
    input  word_t             vk          [NUM_RS],
    output logic              issue_valid,
    output alu_op_t           issue_alu_op,
    output br_type_t          issue_branch_type,
    output rob_tag_t          issue_rob_entry,
    output word_t             issue_vj,
    output word_t             issue_vk,
    output logic [NUM_RS-1:0] consume
);

    always_comb begin
        issue_valid       = 1'b0;
        issue_alu_op      = ALU_ADD;
        issue_branch_type = BR_NONE;
        issue_rob_entry   = '0;
        issue_vj          = '0;
        issue_vk          = '0;
        consume           = '0;
        // Walk from the top down so the lowest ready index wins
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (ready_bus[i]) begin
                issue_valid       = 1'b1;
                issue_alu_op      = alu_op[i];
                issue_branch_type = branch_type[i];
                issue_rob_entry   = rob_entry[i];
                issue_vj          = vj[i];
                issue_vk          = vk[i];
                consume           = '0;
                consume[i]        = 1'b1;
            end
        end
    end

endmodule

// File: hdl/rs_bank.sv
//////////////////////////////
// Reservation station bank
// NUM_RS entries with dispatch decode
//////////////////////////////

`timescale 1ns/1ps

module rs_bank import ooo_pkg::*; #(
    parameter int NUM_RS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mispredicted,
    input  logic              stall,
    input  rs_sel_t           rs_dest,
    input  alu_op_t           d_alu_op,
    input  br_type_t          d_branch_type,
    input  rob_tag_t          d_rob_entry,
    input  rob_tag_t          d_qj,
    input  rob_tag_t          d_qk,
    input  word_t             d_vj,
    input  word_t             d_vk,
    input  logic              cdb_valid,
    input  rob_tag_t          cdb_rob_entry,
    input  word_t             cdb_result,
    input  logic [NUM_RS-1:0] consume,
    output logic [NUM_RS-1:0] busy_bus,
    output logic [NUM_RS-1:0] ready_bus,
    output alu_op_t           alu_op      [NUM_RS],
    output br_type_t          branch_type [NUM_RS],
    output rob_tag_t          rob_entry   [NUM_RS],
    output word_t             vj          [NUM_RS],
    output word_t             vk          [NUM_RS]
);
    logic [NUM_RS-1:0] wr_en;

    for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
        // One-hot write select; targets past the last station write nothing
        assign wr_en[i] = !stall && (rs_dest == rs_sel_t'(i));

        rs_entry u_entry (
            .clk           (clk),
            .reset         (reset),
            .flush         (mispredicted),
            .consume       (consume[i]),
            .wr_en         (wr_en[i]),
            .d_alu_op      (d_alu_op),
            .d_branch_type (d_branch_type),
            .d_rob_entry   (d_rob_entry),
            .d_qj          (d_qj),
            .d_qk          (d_qk),
            .d_vj          (d_vj),
            .d_vk          (d_vk),
            .cdb_valid     (cdb_valid),
            .cdb_rob_entry (cdb_rob_entry),
            .cdb_result    (cdb_result),
            .busy          (busy_bus[i]),
            .ready         (ready_bus[i]),
            .alu_op        (alu_op[i]),
            .branch_type   (branch_type[i]),
            .rob_entry     (rob_entry[i]),
            .vj            (vj[i]),
            .vk            (vk[i])
        );
    end

endmodule

// File: hdl/rs_entry.sv
//////////////////////////////
// Reservation station entry
// Holds one instruction, snoops the CDB
// for missing operands, flags ready
//////////////////////////////

`timescale 1ns/1ps

module rs_entry import ooo_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     consume,
    input  logic     wr_en,
    input  alu_op_t  d_alu_op,
    input  br_type_t d_branch_type,
    input  rob_tag_t d_rob_entry,
    input  rob_tag_t d_qj,
    input  rob_tag_t d_qk,
    input  word_t    d_vj,
    input  word_t    d_vk,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_rob_entry,
    input  word_t    cdb_result,
    output logic     busy,
    output logic     ready,
    output alu_op_t  alu_op,
    output br_type_t branch_type,
    output rob_tag_t rob_entry,
    output word_t    vj,
    output word_t    vk
);
    rob_tag_t qj;
    rob_tag_t qk;

    logic hit_j;
    logic hit_k;
    logic d_hit_j;
    logic d_hit_k;

    // Broadcast matches a held waiting tag
    assign hit_j = cdb_valid && (qj != '0) && (qj == cdb_rob_entry);
    assign hit_k = cdb_valid && (qk != '0) && (qk == cdb_rob_entry);

    // Broadcast matches a tag being written this edge
    assign d_hit_j = cdb_valid && (d_qj != '0) && (d_qj == cdb_rob_entry);
    assign d_hit_k = cdb_valid && (d_qk != '0) && (d_qk == cdb_rob_entry);

    always_ff @(posedge clk) begin
        if (reset || flush || consume) begin
            busy      <= 1'b0;
            qj        <= '0;
            qk        <= '0;
            rob_entry <= '0;
        end else if (wr_en) begin
            busy        <= 1'b1;
            rob_entry   <= d_rob_entry;
            alu_op      <= d_alu_op;
            branch_type <= d_branch_type;
            // Forward a same-edge broadcast so the wakeup is not lost
            qj <= d_hit_j ? rob_tag_t'(0) : d_qj;
            vj <= d_hit_j ? cdb_result : d_vj;
            qk <= d_hit_k ? rob_tag_t'(0) : d_qk;
            vk <= d_hit_k ? cdb_result : d_vk;
        end else begin
            if (hit_j) begin
                qj <= '0;
                vj <= cdb_result;
            end
            if (hit_k) begin
                qk <= '0;
                vk <= cdb_result;
            end
        end
    end

    // Both operands in hand and a real ROB slot
    assign ready = busy && (qj == '0) && (qk == '0) && (rob_entry != '0);

endmodule

// File: hdl/ooo_pkg.sv
//////////////////////////////
// Out-of-order core types
// Shared widths, ALU opcodes and branch kinds
//////////////////////////////

package ooo_pkg;

    // Operand and result value
    typedef logic [31:0] word_t;

    // ROB entry number, also the CDB tag; 0 means no producer
    typedef logic [3:0] rob_tag_t;

    // Dispatch target station
    typedef logic [2:0] rs_sel_t;

    // ALU operation and branch kind
    typedef logic [2:0] alu_op_t;
    typedef logic [1:0] br_type_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;
    // Signed set-less-than
    localparam alu_op_t ALU_SLT = 3'd7;

    localparam br_type_t BR_NONE = 2'd0;
    localparam br_type_t BR_EQ   = 2'd1;
    localparam br_type_t BR_NE   = 2'd2;
    // Signed compare
    localparam br_type_t BR_LT   = 2'd3;

endpackage
